// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    // Architectural register and bus width
    localparam int XLEN = 32;

    // A data or instruction word
    typedef logic [XLEN-1:0] word_t;

    // Byte address as seen by the core
    typedef logic [XLEN-1:0] addr_t;

    // Word address, the byte address without its two low bits
    typedef logic [XLEN-3:0] waddr_t;

    // Instruction returned to the core, err set when the bus answered with an error
    typedef struct packed {
        word_t instr;
        logic  err;
    } fetch_rsp_t;

    // Branch request from execute, valid for a single cycle
    typedef struct packed {
        logic  valid;
        addr_t target;
    } branch_t;

endpackage

// ==== common/wb_bus_pkg.sv ====
package wb_bus_pkg;

    import rv_core_pkg::*;

    // Master to slave half of a classic Wishbone cycle
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        waddr_t     adr;
        logic [3:0] sel;
        word_t      dat;
    } wb_req_t;

    // Slave to master half, ack and err are single cycle pulses
    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } wb_rsp_t;

    // Which master currently holds the shared bus
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } bus_owner_e;

endpackage

// ==== hw/fetch/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit
    import rv_core_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    instr_done_i,
    input  branch_t branch_i,
    input  logic    vec_load_i,
    input  word_t   vec_pc_i,
    input  logic    save_epc_i,
    output addr_t   pc_o,
    output addr_t   uepc_o
);

    addr_t pc_q;
    addr_t uepc_q;

    // Vector load wins over a branch, which wins over the plain step
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (vec_load_i) begin
            pc_q <= vec_pc_i;
        end else if (branch_i.valid) begin
            pc_q <= branch_i.target;
        end else if (instr_done_i) begin
            pc_q <= pc_q + addr_t'(4);
        end
    end

    // The current PC already points past the last delivered instruction
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            uepc_q <= '0;
        end else if (save_epc_i) begin
            uepc_q <= pc_q;
        end
    end

    assign pc_o   = pc_q;
    assign uepc_o = uepc_q;

    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (vec_load_i || branch_i.valid || instr_done_i) |=> (pc_q[1:0] == 2'b00)
    );

endmodule

// ==== hw/fetch/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl
    import rv_core_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       advance_i,
    input  addr_t      pc_i,
    input  logic       irq_i,
    input  addr_t      vtable_base_i,
    input  addr_t      vtable_offset_i,
    output wb_req_t    bus_req_o,
    input  wb_rsp_t    bus_rsp_i,
    input  logic       bus_gnt_i,
    output fetch_rsp_t fetch_rsp_o,
    output logic       data_ready_o,
    output logic       vec_load_o,
    output word_t      vec_pc_o,
    output logic       save_epc_o
);

    typedef enum logic [1:0] {
        VEC_IDLE,
        VEC_WAIT,
        VEC_LOAD
    } vec_state_e;

    typedef enum logic [1:0] {
        PF_IDLE,
        PF_WAIT,
        PF_DONE
    } pf_state_e;

    vec_state_e vec_state_q;
    pf_state_e  pf_state_q;

    logic   initialized_q;
    logic   irq_pending_q;
    logic   req_active_q;
    waddr_t req_adr_q;
    word_t  instr_q;
    logic   instr_err_q;
    logic   data_ready_q;
    logic   vec_load_q;
    word_t  vec_pc_q;
    logic   save_epc_q;

    addr_t vec_addr;
    logic  both_idle;
    logic  take_vector;
    logic  vec_start;
    logic  pf_start;
    logic  bus_done;
    logic  vec_served;

    assign vec_addr    = vtable_base_i + vtable_offset_i;
    assign both_idle   = (vec_state_q == VEC_IDLE) && (pf_state_q == PF_IDLE);
    assign take_vector = !initialized_q || irq_pending_q;
    assign vec_start   = advance_i && both_idle && take_vector;
    assign pf_start    = advance_i && both_idle && !take_vector;

    // The bus answer only counts while this master owns the bus
    assign bus_done   = bus_gnt_i && (bus_rsp_i.ack || bus_rsp_i.err);
    assign vec_served = (vec_state_q == VEC_WAIT) && bus_gnt_i && bus_rsp_i.ack;

    // Interrupt stays pending until a vector lookup completes
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_pending_q <= 1'b0;
        end else if (vec_served) begin
            irq_pending_q <= 1'b0;
        end else if (irq_i) begin
            irq_pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vec_state_q   <= VEC_IDLE;
            pf_state_q    <= PF_IDLE;
            req_active_q  <= 1'b0;
            data_ready_q  <= 1'b0;
            vec_load_q    <= 1'b0;
            save_epc_q    <= 1'b0;
            initialized_q <= 1'b0;
        end else begin
            data_ready_q <= 1'b0;
            vec_load_q   <= 1'b0;
            save_epc_q   <= 1'b0;

            case (vec_state_q)
                VEC_IDLE: begin
                    if (vec_start) begin
                        req_active_q <= 1'b1;
                        save_epc_q   <= 1'b1;
                        vec_state_q  <= VEC_WAIT;
                    end
                end
                VEC_WAIT: begin
                    if (bus_done) begin
                        req_active_q <= 1'b0;
                        // An error leaves the core uninitialized so the lookup is retried
                        if (bus_rsp_i.ack) begin
                            vec_load_q    <= 1'b1;
                            initialized_q <= 1'b1;
                        end
                        vec_state_q <= VEC_LOAD;
                    end
                end
                // One extra cycle lets the PC settle before the next advance
                VEC_LOAD: vec_state_q <= VEC_IDLE;
                default:  vec_state_q <= VEC_IDLE;
            endcase

            case (pf_state_q)
                PF_IDLE: begin
                    if (pf_start) begin
                        req_active_q <= 1'b1;
                        pf_state_q   <= PF_WAIT;
                    end
                end
                PF_WAIT: begin
                    if (bus_done) begin
                        req_active_q <= 1'b0;
                        data_ready_q <= 1'b1;
                        pf_state_q   <= PF_DONE;
                    end
                end
                PF_DONE: pf_state_q <= PF_IDLE;
                default: pf_state_q <= PF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (vec_start) begin
            req_adr_q <= vec_addr[XLEN-1:2];
        end else if (pf_start) begin
            req_adr_q <= pc_i[XLEN-1:2];
        end
        if ((vec_state_q == VEC_WAIT) && bus_done) begin
            vec_pc_q <= bus_rsp_i.dat;
        end
        if ((pf_state_q == PF_WAIT) && bus_done) begin
            instr_q     <= bus_rsp_i.dat;
            instr_err_q <= bus_rsp_i.err;
        end
    end

    assign bus_req_o = '{
        cyc: req_active_q,
        stb: req_active_q,
        we:  1'b0,
        adr: req_adr_q,
        sel: 4'b1111,
        dat: '0
    };

    assign fetch_rsp_o  = '{instr: instr_q, err: instr_err_q};
    assign data_ready_o = data_ready_q;
    assign vec_load_o   = vec_load_q;
    assign vec_pc_o     = vec_pc_q;
    assign save_epc_o   = save_epc_q;

    a_paths_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !((vec_state_q != VEC_IDLE) && (pf_state_q != PF_IDLE))
    );

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
    import wb_bus_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t fetch_req_i,
    input  wb_req_t data_req_i,
    output wb_rsp_t fetch_rsp_o,
    output wb_rsp_t data_rsp_o,
    output logic    fetch_gnt_o,
    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i
);

    bus_owner_e owner_q;
    bus_owner_e owner_c;
    logic       owner_held;

    // The registered owner keeps the bus only while its cycle is still open
    assign owner_held = ((owner_q == OWN_FETCH) && fetch_req_i.cyc) ||
                        ((owner_q == OWN_DATA) && data_req_i.cyc);

    always_comb begin
        if (owner_held) begin
            owner_c = owner_q;
        end else if (data_req_i.cyc) begin
            owner_c = OWN_DATA;
        end else if (fetch_req_i.cyc) begin
            owner_c = OWN_FETCH;
        end else begin
            owner_c = OWN_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_c;
        end
    end

    always_comb begin
        mem_req_o   = '0;
        fetch_rsp_o = '0;
        data_rsp_o  = '0;
        case (owner_c)
            OWN_FETCH: begin
                mem_req_o   = fetch_req_i;
                fetch_rsp_o = mem_rsp_i;
            end
            OWN_DATA: begin
                mem_req_o  = data_req_i;
                data_rsp_o = mem_rsp_i;
            end
            default: ;
        endcase
    end

    assign fetch_gnt_o = (owner_c == OWN_FETCH);

    // The slave only answers a granted strobe, so an answer always has an owner
    a_rsp_has_owner: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (mem_rsp_i.ack || mem_rsp_i.err) |-> (owner_c != OWN_NONE)
    );

endmodule

// ==== hw/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram
    import rv_core_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t mem_q [MEM_WORDS];

    logic             ack_q;
    logic             err_q;
    word_t            rdata_q;
    logic             req_valid;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // A strobe still held in the cycle of its answer is not served twice
    assign req_valid = req_i.cyc && req_i.stb && !ack_q && !err_q;
    assign in_range  = ({2'b00, req_i.adr} < MEM_WORDS);
    assign idx       = req_i.adr[IDX_W-1:0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req_valid && in_range;
            err_q <= req_valid && !in_range;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid && in_range) begin
            if (req_i.we) begin
                mem_q[idx] <= req_i.dat;
            end
            rdata_q <= mem_q[idx];
        end
    end

    assign rsp_o = '{ack: ack_q, err: err_q, dat: rdata_q};

endmodule

// ==== hw/fetch_subsys.sv ====
`timescale 1ns/1ps

module fetch_subsys
    import rv_core_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       advance_i,
    output fetch_rsp_t fetch_rsp_o,
    output logic       data_ready_o,
    input  branch_t    branch_i,
    input  logic       irq_i,
    input  addr_t      vtable_base_i,
    input  addr_t      vtable_offset_i,
    output addr_t      pc_o,
    output addr_t      uepc_o,
    input  wb_req_t    data_req_i,
    output wb_rsp_t    data_rsp_o
);

    wb_req_t fetch_req;
    wb_rsp_t fetch_rsp;
    logic    fetch_gnt;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;
    logic    vec_load;
    word_t   vec_pc;
    logic    save_epc;

    fetch_ctrl u_fetch_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .advance_i       (advance_i),
        .pc_i            (pc_o),
        .irq_i           (irq_i),
        .vtable_base_i   (vtable_base_i),
        .vtable_offset_i (vtable_offset_i),
        .bus_req_o       (fetch_req),
        .bus_rsp_i       (fetch_rsp),
        .bus_gnt_i       (fetch_gnt),
        .fetch_rsp_o     (fetch_rsp_o),
        .data_ready_o    (data_ready_o),
        .vec_load_o      (vec_load),
        .vec_pc_o        (vec_pc),
        .save_epc_o      (save_epc)
    );

    // Every delivered instruction moves the PC on by one word
    pc_unit u_pc_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_done_i (data_ready_o),
        .branch_i     (branch_i),
        .vec_load_i   (vec_load),
        .vec_pc_i     (vec_pc),
        .save_epc_i   (save_epc),
        .pc_o         (pc_o),
        .uepc_o       (uepc_o)
    );

    bus_arbiter u_bus_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .fetch_req_i (fetch_req),
        .data_req_i  (data_req_i),
        .fetch_rsp_o (fetch_rsp),
        .data_rsp_o  (data_rsp_o),
        .fetch_gnt_o (fetch_gnt),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    wb_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_wb_ram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (mem_req),
        .rsp_o   (mem_rsp)
    );

endmodule

// ==== dv/tb_fetch_subsys.sv ====
`timescale 1ns/1ps

module tb_fetch_subsys
    import rv_core_pkg::*;
    import wb_bus_pkg::*;
;

    localparam int unsigned MEM_WORDS   = 1024;
    localparam addr_t       VTABLE_BASE = 32'h0000_0F00;
    localparam addr_t       RESET_PC    = 32'h0000_0100;
    localparam addr_t       HANDLER_PC  = 32'h0000_0200;
    localparam addr_t       BRANCH_PC   = 32'h0000_0300;
    localparam addr_t       SCRATCH     = 32'h0000_0800;
    localparam addr_t       ERR_PC      = addr_t'(MEM_WORDS * 4 + 32'h40);
    localparam int          PROG_WORDS  = 4;

    // Two vector entries, the program, one branch target and two handler words
    localparam int PRELOAD_XFERS  = 2 + PROG_WORDS + 1 + 2;
    // One lookup, four fetches, one branch fetch, lookup and fetch, three for contention, one error
    localparam int TEST_XFERS     = 1 + PROG_WORDS + 1 + 2 + 3 + 1;
    localparam int TIMEOUT_CYCLES = (PRELOAD_XFERS + TEST_XFERS) * 20 + 50;

    logic       clk_i;
    logic       reset_i;
    logic       advance_i;
    fetch_rsp_t fetch_rsp_o;
    logic       data_ready_o;
    branch_t    branch_i;
    logic       irq_i;
    addr_t      vtable_base_i;
    addr_t      vtable_offset_i;
    addr_t      pc_o;
    addr_t      uepc_o;
    wb_req_t    data_req_i;
    wb_rsp_t    data_rsp_o;

    word_t  mem_model [MEM_WORDS];
    integer seed = 32'h64dd;
    int     cycle_count = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    int     errors_at_start = 0;
    string  test_name;
    addr_t  exp_pc;

    fetch_subsys #(
        .MEM_WORDS (MEM_WORDS)
    ) u_fetch_subsys (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .advance_i       (advance_i),
        .fetch_rsp_o     (fetch_rsp_o),
        .data_ready_o    (data_ready_o),
        .branch_i        (branch_i),
        .irq_i           (irq_i),
        .vtable_base_i   (vtable_base_i),
        .vtable_offset_i (vtable_offset_i),
        .pc_o            (pc_o),
        .uepc_o          (uepc_o),
        .data_req_i      (data_req_i),
        .data_rsp_o      (data_rsp_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s: %s expected %08h, got %08h", test_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s: %s expected %08h, got %08h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s: %s expected %b, got %b", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = n_errors;
    endtask

    task automatic end_test();
        $display("%-20s finished with %0d mismatches", test_name, n_errors - errors_at_start);
    endtask

    // The master keeps cyc up through the edge that samples its ack and drops it a cycle later
    task automatic bus_cycle(input addr_t addr, input logic we, input word_t wdata,
                             output word_t rdata);
        data_req_i.cyc = 1'b1;
        data_req_i.stb = 1'b1;
        data_req_i.we  = we;
        data_req_i.adr = addr[XLEN-1:2];
        data_req_i.sel = 4'b1111;
        data_req_i.dat = wdata;
        @(negedge clk_i);
        while (!data_rsp_o.ack && !data_rsp_o.err) begin
            @(negedge clk_i);
        end
        rdata = data_rsp_o.dat;
        if (data_rsp_o.err) begin
            n_errors++;
            $display("Data port access to %08h was answered with a bus error", addr);
        end
        @(negedge clk_i);
        data_req_i = '0;
    endtask

    task automatic preload(input addr_t addr, input word_t data);
        word_t unused;
        bus_cycle(addr, 1'b1, data, unused);
        mem_model[addr >> 2] = data;
    endtask

    // The lookup has no external done pulse, so its internal vector load marks the end
    task automatic advance_and_wait(output logic got_ready, output logic got_vec,
                                    output fetch_rsp_t rsp);
        advance_i = 1'b1;
        @(negedge clk_i);
        advance_i = 1'b0;
        while (!data_ready_o && !u_fetch_subsys.vec_load) begin
            @(negedge clk_i);
        end
        got_ready = data_ready_o;
        got_vec   = u_fetch_subsys.vec_load;
        rsp       = fetch_rsp_o;
        @(negedge clk_i);
    endtask

    task automatic redirect(input addr_t target);
        branch_i.valid  = 1'b1;
        branch_i.target = target;
        @(negedge clk_i);
        branch_i = '0;
        exp_pc = target;
        check_addr("pc after branch", target, pc_o);
    endtask

    task automatic fetch_and_check(input string what);
        logic       got_ready;
        logic       got_vec;
        fetch_rsp_t rsp;
        advance_and_wait(got_ready, got_vec, rsp);
        check_flag({what, " ready"}, 1'b1, got_ready);
        check_word({what, " instr"}, mem_model[exp_pc >> 2], rsp.instr);
        check_flag({what, " err"}, 1'b0, rsp.err);
        exp_pc = exp_pc + 4;
        check_addr({what, " next pc"}, exp_pc, pc_o);
    endtask

    task automatic preload_memory();
        preload(VTABLE_BASE, RESET_PC);
        preload(VTABLE_BASE + 4, HANDLER_PC);
        for (int i = 0; i < PROG_WORDS; i++) begin
            preload(RESET_PC + addr_t'(4 * i), $random(seed));
        end
        preload(BRANCH_PC, $random(seed));
        preload(HANDLER_PC, $random(seed));
        preload(HANDLER_PC + 4, $random(seed));
    endtask

    task automatic reset_vector_lookup();
        logic       got_ready;
        logic       got_vec;
        fetch_rsp_t rsp;
        start_test("reset_vector");
        check_addr("pc out of reset", '0, pc_o);
        advance_and_wait(got_ready, got_vec, rsp);
        check_flag("data_ready during lookup", 1'b0, got_ready);
        check_flag("vector load", 1'b1, got_vec);
        check_addr("pc after lookup", RESET_PC, pc_o);
        exp_pc = RESET_PC;
        end_test();
    endtask

    task automatic sequential_fetch();
        start_test("sequential");
        for (int i = 0; i < PROG_WORDS; i++) begin
            fetch_and_check($sformatf("fetch %0d", i));
        end
        end_test();
    endtask

    task automatic branch_redirect();
        start_test("branch");
        redirect(BRANCH_PC);
        fetch_and_check("target fetch");
        end_test();
    endtask

    task automatic interrupt_entry();
        logic       got_ready;
        logic       got_vec;
        fetch_rsp_t rsp;
        addr_t      pending_pc;
        start_test("interrupt");
        pending_pc = exp_pc;
        vtable_offset_i = 32'h4;
        irq_i = 1'b1;
        @(negedge clk_i);
        irq_i = 1'b0;
        advance_and_wait(got_ready, got_vec, rsp);
        check_flag("data_ready during lookup", 1'b0, got_ready);
        check_flag("vector load", 1'b1, got_vec);
        check_addr("pc after lookup", HANDLER_PC, pc_o);
        check_addr("uepc", pending_pc, uepc_o);
        exp_pc = HANDLER_PC;
        fetch_and_check("handler fetch");
        end_test();
    endtask

    task automatic bus_contention();
        logic       got_ready;
        logic       got_vec;
        fetch_rsp_t rsp;
        word_t      wdata;
        word_t      rdata;
        word_t      unused;
        start_test("contention");
        wdata = $random(seed);
        fork
            bus_cycle(SCRATCH, 1'b1, wdata, unused);
            advance_and_wait(got_ready, got_vec, rsp);
        join
        mem_model[SCRATCH >> 2] = wdata;
        check_flag("fetch ready", 1'b1, got_ready);
        check_word("fetch instr", mem_model[exp_pc >> 2], rsp.instr);
        check_flag("fetch err", 1'b0, rsp.err);
        exp_pc = exp_pc + 4;
        check_addr("next pc", exp_pc, pc_o);
        bus_cycle(SCRATCH, 1'b0, '0, rdata);
        check_word("data port readback", wdata, rdata);
        end_test();
    endtask

    task automatic out_of_range_fetch();
        logic       got_ready;
        logic       got_vec;
        fetch_rsp_t rsp;
        start_test("bus_error");
        redirect(ERR_PC);
        advance_and_wait(got_ready, got_vec, rsp);
        check_flag("fetch ready", 1'b1, got_ready);
        check_flag("fetch err", 1'b1, rsp.err);
        check_addr("next pc", ERR_PC + 4, pc_o);
        end_test();
    endtask

    initial begin
        clk_i           = 1'b0;
        reset_i         = 1'b1;
        advance_i       = 1'b0;
        branch_i        = '0;
        irq_i           = 1'b0;
        vtable_base_i   = VTABLE_BASE;
        vtable_offset_i = '0;
        data_req_i      = '0;
        exp_pc          = '0;
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);

        preload_memory();
        reset_vector_lookup();
        sequential_fetch();
        branch_redirect();
        interrupt_entry();
        bus_contention();
        out_of_range_fetch();

        $display("Checks run: %0d, mismatches: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv_fetch.f ====
common/rv_core_pkg.sv
common/wb_bus_pkg.sv
hw/fetch/pc_unit.sv
hw/fetch/fetch_ctrl.sv
hw/bus_arbiter.sv
hw/wb_ram.sv
hw/fetch_subsys.sv
dv/tb_fetch_subsys.sv

// ==== Bender.yml ====
package:
  name: rv_fetch

sources:
  # Packages first, the bus package builds on the core package
  - common/rv_core_pkg.sv
  - common/wb_bus_pkg.sv
  # Fetch subsystem RTL
  - hw/fetch/pc_unit.sv
  - hw/fetch/fetch_ctrl.sv
  - hw/bus_arbiter.sv
  - hw/wb_ram.sv
  - hw/fetch_subsys.sv
  # Directed testbench
  - target: test
    files:
      - dv/tb_fetch_subsys.sv
